//--- tests/fetch_golden.txt
// 00-0f: memory words, 10: redirect count, 11-14: (taken count, target pc) pairs
// 18: expected instruction count, 19 on: expected {pc[31:0], ir} per taken instruction
@00
c0de0004c0de0000 c0de000cc0de0008 c0de0014c0de0010 c0de001cc0de0018
c0de0024c0de0020 c0de002cc0de0028 c0de0034c0de0030 c0de003cc0de0038
c0de0044c0de0040 c0de004cc0de0048 c0de0054c0de0050 c0de005cc0de0058
c0de0064c0de0060 c0de006cc0de0068 c0de0074c0de0070 c0de007cc0de0078
@10
2 a 40 1a 0
@18
32
@19
00000000c0de0000 00000004c0de0004 00000008c0de0008 0000000cc0de000c
00000010c0de0010 00000014c0de0014 00000018c0de0018 0000001cc0de001c
00000020c0de0020 00000024c0de0024 00000040c0de0040 00000044c0de0044
00000048c0de0048 0000004cc0de004c 00000050c0de0050 00000054c0de0054
00000058c0de0058 0000005cc0de005c 00000060c0de0060 00000064c0de0064
00000068c0de0068 0000006cc0de006c 00000070c0de0070 00000074c0de0074
00000078c0de0078 0000007cc0de007c 00000000c0de0000 00000004c0de0004
00000008c0de0008 0000000cc0de000c 00000010c0de0010 00000014c0de0014
00000018c0de0018 0000001cc0de001c 00000020c0de0020 00000024c0de0024
00000028c0de0028 0000002cc0de002c 00000030c0de0030 00000034c0de0034
00000038c0de0038 0000003cc0de003c 00000040c0de0040 00000044c0de0044
00000048c0de0048 0000004cc0de004c 00000050c0de0050 00000054c0de0054
00000058c0de0058 0000005cc0de005c

//--- all.f
logic/fetch_pkg.sv
logic/icache_mem.sv
logic/icache_ctrl.sv
logic/fetch_stage.sv
logic/fetch_buffer.sv
logic/fetch_top.sv
tests/imem_model.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module fetch_tb -f all.f -o fetch_sim > sim.log 2>&1 \
  && ./obj_dir/fetch_sim >> sim.log 2>&1 \
  || echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
exit 0

//--- tests/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;
  import fetch_pkg::*;

  localparam int GOLD_WORDS = 128;
  localparam int REDIR_BASE = 16;   // Redirect count, then pairs of (taken count, target)
  localparam int NEXP_IDX   = 24;
  localparam int SEQ_BASE   = 25;   // Expected {pc, ir} stream

  logic                 clock;
  logic                 rst;
  logic [MEM_TAG_W-1:0] mem2proc_response;
  logic [63:0]          mem2proc_data;
  logic [MEM_TAG_W-1:0] mem2proc_tag;
  bus_cmd_t             proc2mem_command;
  logic [ADDR_W-1:0]    proc2mem_addr;
  logic                 redirect_en;
  logic [ADDR_W-1:0]    redirect_pc;
  logic                 take;
  logic                 inst_valid;
  logic [ADDR_W-1:0]    inst_pc;
  logic [INST_W-1:0]    inst_ir;

  logic [63:0]       golden [GOLD_WORDS];
  integer            seed = 91;
  int                errors;
  int                checks;
  int                taken;
  int                n_exp;
  int                n_redir;
  int                redir_idx;
  int                cycles;
  int                limit;
  logic              running;
  logic              first_cycle;
  logic              fill_seen;
  logic              hits_only;
  logic [ADDR_W-1:0] exp_pc;

  fetch_top #(.FB_DEPTH(8)) UUT (
    .clock             (clock),
    .rst               (rst),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .redirect_en       (redirect_en),
    .redirect_pc       (redirect_pc),
    .take              (take),
    .inst_valid        (inst_valid),
    .inst_pc           (inst_pc),
    .inst_ir           (inst_ir)
  );

  imem_model mem_model (
    .clock             (clock),
    .rst               (rst),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH time=%0t %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  // Half of the memory word picked by PC bit 2
  function automatic logic [31:0] word_half(input logic [63:0] pc);
    logic [63:0] word;
    word = golden[pc[6:3]];
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  initial begin
    rst = 1'b1;
    take = 1'b0;
    redirect_en = 1'b0;
    redirect_pc = '0;
    running = 1'b0;
    first_cycle = 1'b1;
    fill_seen = 1'b0;
    hits_only = 1'b0;
    exp_pc = '0;
    $readmemh("tests/fetch_golden.txt", golden);
    for (int i = 0; i < 16; i++) begin
      mem_model.image[i] = golden[i];
    end
    n_redir = int'(golden[REDIR_BASE]);
    n_exp   = int'(golden[NEXP_IDX]);
    limit   = 40 * n_exp + 200;
    repeat (16) @(posedge clock);
    rst <= 1'b0;
    running <= 1'b1;
    while (taken < n_exp && cycles < limit) @(posedge clock);
    if (taken < n_exp) begin
      errors++;
      $display("Timeout: only %0d of %0d instructions taken in %0d cycles",
               taken, n_exp, cycles);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Stimulus on the rising edge
  always @(posedge clock) begin
    if (running) begin
      if (taken < n_exp && redir_idx < n_redir &&
          taken == int'(golden[REDIR_BASE + 1 + 2*redir_idx])) begin
        redirect_en  <= 1'b1;
        redirect_pc  <= golden[REDIR_BASE + 2 + 2*redir_idx];
        take         <= 1'b0;
        redir_idx++;
      end else if (taken < n_exp) begin
        redirect_en <= 1'b0;
        take        <= ($unsigned($random(seed)) % 100) < 60;   // About 60 percent
      end else begin
        redirect_en <= 1'b0;
        take        <= 1'b0;
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clock) begin
    if (running) begin
      cycles++;
      if (first_cycle) begin
        check("proc2mem_command", 64'(proc2mem_command), 64'(bus_load));
        check("proc2mem_addr", proc2mem_addr, 64'h0);
        first_cycle = 1'b0;
      end
      if (mem2proc_tag != '0) fill_seen = 1'b1;
      if (!fill_seen) check("inst_valid", 64'(inst_valid), 64'h0);
      if (proc2mem_command == bus_load) begin
        check("proc2mem_addr[2:0]", 64'(proc2mem_addr[2:0]), 64'h0);
      end
      if (hits_only && taken < n_exp) begin
        check("proc2mem_command", 64'(proc2mem_command), 64'(bus_none));  // All hits now
      end
      if (redirect_en) begin
        exp_pc = redirect_pc;   // Next taken PC is the target
      end
      if (take && inst_valid && !redirect_en && taken < n_exp) begin
        check("inst_pc", inst_pc, {32'h0, golden[SEQ_BASE + taken][63:32]});
        check("inst_pc", inst_pc, exp_pc);   // No gap, no repeat
        check("inst_ir", 64'(inst_ir), 64'(golden[SEQ_BASE + taken][31:0]));
        check("inst_ir", 64'(inst_ir), 64'(word_half(exp_pc)));
        if (redir_idx == n_redir && exp_pc == 64'h40) hits_only = 1'b1;
        exp_pc = exp_pc + 64'd4;
        taken++;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/imem_model.sv
`timescale 1ns/100ps
`default_nettype none

module imem_model (
  input  logic                            clock,
  input  logic                            rst,
  input  fetch_pkg::bus_cmd_t             proc2mem_command,
  input  logic [fetch_pkg::ADDR_W-1:0]    proc2mem_addr,
  output logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_response,
  output logic [63:0]                     mem2proc_data,
  output logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_tag
);
  import fetch_pkg::*;

  localparam int SLOTS = 4;
  localparam int DELAY = 6;   // Cycles from accept to data

  logic [63:0]          image [16];
  logic [MEM_TAG_W-1:0] next_tag = 4'd1;
  logic [MEM_TAG_W-1:0] ret_tag = '0;
  logic [63:0]          ret_data = '0;
  logic [SLOTS-1:0]     slot_busy = '0;
  logic [MEM_TAG_W-1:0] slot_tag [SLOTS];
  logic [3:0]           slot_blk [SLOTS];
  int                   slot_cnt [SLOTS];
  int                   in_flight;
  int                   free_slot;
  logic                 accept;

  always_comb begin
    in_flight = 0;
    free_slot = 0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (slot_busy[i]) in_flight++;
      else free_slot = i;
    end
  end

  assign accept            = !rst && (proc2mem_command == bus_load) && (in_flight <= 3);
  assign mem2proc_response = accept ? next_tag : '0;
  assign mem2proc_tag      = ret_tag;
  assign mem2proc_data     = ret_data;

  always @(posedge clock) begin : serve
    logic sent;
    sent = 1'b0;
    ret_tag <= '0;
    if (rst) begin
      slot_busy <= '0;
      next_tag  <= 4'd1;
    end else begin
      for (int i = 0; i < SLOTS; i++) begin
        if (slot_busy[i] && slot_cnt[i] > 0) begin
          slot_cnt[i] <= slot_cnt[i] - 1;
        end else if (slot_busy[i] && !sent) begin
          ret_tag      <= slot_tag[i];
          ret_data     <= image[slot_blk[i]];
          slot_busy[i] <= 1'b0;
          sent = 1'b1;
        end
      end
      if (accept) begin
        slot_busy[free_slot] <= 1'b1;
        slot_tag[free_slot]  <= next_tag;
        slot_blk[free_slot]  <= proc2mem_addr[6:3];   // Image wraps every 128 bytes
        slot_cnt[free_slot]  <= DELAY - 1;
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
  parameter int FB_DEPTH = 8
) (
  input  logic                            clock,
  input  logic                            rst,
  input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_response,
  input  logic [63:0]                     mem2proc_data,
  input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_tag,
  output fetch_pkg::bus_cmd_t             proc2mem_command,
  output logic [fetch_pkg::ADDR_W-1:0]    proc2mem_addr,
  input  logic                            redirect_en,
  input  logic [fetch_pkg::ADDR_W-1:0]    redirect_pc,
  input  logic                            take,
  output logic                            inst_valid,
  output logic [fetch_pkg::ADDR_W-1:0]    inst_pc,
  output logic [fetch_pkg::INST_W-1:0]    inst_ir
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] fetch_addr;
  cache_block_t      cache_block;
  logic              cache_valid;
  logic [IDX_W-1:0]  rd_idx;
  logic [TAG_W-1:0]  rd_tag;
  logic              wr_en;
  logic [IDX_W-1:0]  wr_idx;
  logic [TAG_W-1:0]  wr_tag;
  logic              fetch_valid;
  logic [ADDR_W-1:0] fetch_pc;
  logic [INST_W-1:0] fetch_ir;
  logic              fb_ready;

  icache_mem icache_mem_0 (
    .clock    (clock),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_tag   (wr_tag),
    .wr_data  (mem2proc_data),    // Fill straight from the bus
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .rd_data  (cache_block),
    .rd_valid (cache_valid)
  );

  icache_ctrl icache_ctrl_0 (
    .clock             (clock),
    .rst               (rst),
    .fetch_addr        (fetch_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .cachemem_valid    (cache_valid),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .rd_idx            (rd_idx),
    .rd_tag            (rd_tag),
    .wr_en             (wr_en),
    .wr_idx            (wr_idx),
    .wr_tag            (wr_tag)
  );

  fetch_stage fetch_stage_0 (
    .clock       (clock),
    .rst         (rst),
    .block       (cache_block),
    .block_valid (cache_valid),
    .fb_ready    (fb_ready),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_ir    (fetch_ir)
  );

  fetch_buffer #(
    .FB_DEPTH (FB_DEPTH)
  ) fetch_buffer_0 (
    .clock      (clock),
    .rst        (rst),
    .push       (fetch_valid),
    .push_pc    (fetch_pc),
    .push_ir    (fetch_ir),
    .take       (take),
    .flush      (redirect_en),    // Redirect empties the queue
    .ready      (fb_ready),
    .inst_valid (inst_valid),
    .inst_pc    (inst_pc),
    .inst_ir    (inst_ir)
  );

endmodule

`default_nettype wire

//--- logic/fetch_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_buffer #(
  parameter int FB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         rst,
  input  logic                         push,
  input  logic [fetch_pkg::ADDR_W-1:0] push_pc,
  input  logic [fetch_pkg::INST_W-1:0] push_ir,
  input  logic                         take,
  input  logic                         flush,
  output logic                         ready,
  output logic                         inst_valid,
  output logic [fetch_pkg::ADDR_W-1:0] inst_pc,
  output logic [fetch_pkg::INST_W-1:0] inst_ir
);
  import fetch_pkg::*;

  localparam int PTR_W = (FB_DEPTH > 1) ? $clog2(FB_DEPTH) : 1;
  localparam int CNT_W = $clog2(FB_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(FB_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(FB_DEPTH);

  logic [ADDR_W-1:0] pc_q [FB_DEPTH];
  logic [INST_W-1:0] ir_q [FB_DEPTH];
  logic [PTR_W-1:0]  head;
  logic [PTR_W-1:0]  tail;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_take;

  assign ready      = (count != FULL);   // At least one free slot
  assign inst_valid = (count != '0);
  assign inst_pc    = pc_q[head];        // Oldest entry
  assign inst_ir    = ir_q[head];

  // Flush overrides both sides
  assign do_push = push && ready && !flush;
  assign do_take = take && inst_valid && !flush;

  always_ff @(posedge clock) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        tail <= (tail == LAST) ? '0 : tail + 1'b1;
      end
      if (do_take) begin
        head <= (head == LAST) ? '0 : head + 1'b1;
      end
      case ({do_push, do_take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // Both or neither
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      pc_q[tail] <= push_pc;
      ir_q[tail] <= push_ir;
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
  input  logic                         clock,
  input  logic                         rst,
  input  fetch_pkg::cache_block_t      block,
  input  logic                         block_valid,
  input  logic                         fb_ready,
  input  logic                         redirect_en,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_addr,
  output logic                         fetch_valid,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
  output logic [fetch_pkg::INST_W-1:0] fetch_ir
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] pc;

  assign fetch_addr = pc;
  assign fetch_pc   = pc;

  // PC bit 2 picks the half of the block
  assign fetch_ir = block.inst[pc[2]];

  // Hit with room in the buffer, never alongside a redirect
  assign fetch_valid = block_valid && fb_ready && !redirect_en;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= '0;
    end else if (redirect_en) begin
      pc <= redirect_pc;
    end else if (fetch_valid) begin
      pc <= pc + ADDR_W'(4);
    end
  end

endmodule

`default_nettype wire

//--- logic/icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl (
  input  logic                            clock,
  input  logic                            rst,
  input  logic [fetch_pkg::ADDR_W-1:0]    fetch_addr,
  input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_response,
  input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_tag,
  input  logic                            cachemem_valid,
  output fetch_pkg::bus_cmd_t             proc2mem_command,
  output logic [fetch_pkg::ADDR_W-1:0]    proc2mem_addr,
  output logic [fetch_pkg::IDX_W-1:0]     rd_idx,
  output logic [fetch_pkg::TAG_W-1:0]     rd_tag,
  output logic                            wr_en,
  output logic [fetch_pkg::IDX_W-1:0]     wr_idx,
  output logic [fetch_pkg::TAG_W-1:0]     wr_tag
);
  import fetch_pkg::*;

  logic [MEM_TAG_W-1:0] pending_tag;
  logic [IDX_W-1:0]     miss_idx;
  logic [TAG_W-1:0]     miss_tag;
  logic                 idle;
  logic                 issue;
  logic                 accepted;
  logic                 fill_hit;

  // Index in bits 7:3, tag in bits 15:8
  assign rd_idx = fetch_addr[IDX_W+2:3];
  assign rd_tag = fetch_addr[TAG_W+IDX_W+2:IDX_W+3];

  assign idle     = (pending_tag == '0);
  assign issue    = idle && !cachemem_valid;        // One load at a time
  assign accepted = issue && (mem2proc_response != '0);
  assign fill_hit = !idle && (mem2proc_tag == pending_tag);

  always_comb begin
    proc2mem_command = bus_none;
    if (issue) begin
      proc2mem_command = bus_load;
    end
  end

  assign proc2mem_addr = {fetch_addr[ADDR_W-1:3], 3'b000};  // Block aligned

  // Refused request retries next cycle since pending stays zero
  always_ff @(posedge clock) begin
    if (rst) begin
      pending_tag <= '0;
    end else if (accepted) begin
      pending_tag <= mem2proc_response;
    end else if (fill_hit) begin
      pending_tag <= '0;
    end
  end

  // Line that the fill returns to, kept even across a redirect
  always_ff @(posedge clock) begin
    if (accepted) begin
      miss_idx <= rd_idx;
      miss_tag <= rd_tag;
    end
  end

  // Data comes straight off the bus in the matching cycle
  assign wr_en  = fill_hit;
  assign wr_idx = miss_idx;
  assign wr_tag = miss_tag;

endmodule

`default_nettype wire

//--- logic/icache_mem.sv
`timescale 1ns/100ps
`default_nettype none

module icache_mem (
  input  logic                        clock,
  input  logic                        rst,
  input  logic                        wr_en,
  input  logic [fetch_pkg::IDX_W-1:0] wr_idx,
  input  logic [fetch_pkg::TAG_W-1:0] wr_tag,
  input  fetch_pkg::cache_block_t     wr_data,
  input  logic [fetch_pkg::IDX_W-1:0] rd_idx,
  input  logic [fetch_pkg::TAG_W-1:0] rd_tag,
  output fetch_pkg::cache_block_t     rd_data,
  output logic                        rd_valid
);
  import fetch_pkg::*;

  localparam int NUM_LINES = 1 << IDX_W;

  cache_block_t           data_mem [NUM_LINES];
  logic [TAG_W-1:0]       tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0]   valid_bits;

  // Combinational lookup
  assign rd_data  = data_mem[rd_idx];
  assign rd_valid = valid_bits[rd_idx] && (tag_mem[rd_idx] == rd_tag);

  always_ff @(posedge clock) begin
    if (rst) begin
      valid_bits <= '0;             // All lines invalid
    end else if (wr_en) begin
      valid_bits[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int ADDR_W    = 64;
  localparam int INST_W    = 32;
  localparam int IDX_W     = 5;   // 32 lines
  localparam int TAG_W     = 8;
  localparam int MEM_TAG_W = 4;   // Zero means no transaction

  // Memory bus commands
  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_cmd_t;

  // One 8-byte memory block, seen as a raw word or as two instructions
  // Element 0 of inst is the low word, at the lower address
  typedef union packed {
    logic [2*INST_W-1:0]    word;
    logic [1:0][INST_W-1:0] inst;
  } cache_block_t;

endpackage

`default_nettype wire
